/* source/issue_pkg.sv */
package issue_pkg;

  localparam int reg_addr_width = 5;
  localparam int xlen = 32;

  // ~~~~~~~~~~~~~~~~~~~~
  // instruction kinds

  typedef enum logic [2:0] {
    class_none,
    class_alu,
    class_mul,
    class_load,
    class_store,
    class_csr,
    class_fence
  } op_class_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_addi,
    alu_lui,
    alu_mul,
    alu_nop
  } alu_op_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // rv32 major opcodes

  localparam logic [6:0] opc_op = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_load = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;
  localparam logic [6:0] opc_system = 7'b1110011;
  localparam logic [6:0] opc_fence = 7'b0001111;

endpackage

/* source/pair_decoder.sv */
module pair_decoder (
  input  logic clock,
  input  logic reset,
  input  logic word0_valid,
  input  logic [issue_pkg::xlen-1:0] word0,
  input  logic word1_valid,
  input  logic [issue_pkg::xlen-1:0] word1,
  input  logic stall,
  output logic dec_lane0_valid,
  output issue_pkg::op_class_e dec_lane0_op_class,
  output issue_pkg::alu_op_e dec_lane0_alu_op,
  output logic [issue_pkg::reg_addr_width-1:0] dec_lane0_waddr,
  output logic [issue_pkg::reg_addr_width-1:0] dec_lane0_raddr1,
  output logic [issue_pkg::reg_addr_width-1:0] dec_lane0_raddr2,
  output logic [issue_pkg::xlen-1:0] dec_lane0_imm,
  output logic dec_lane0_wren,
  output logic dec_lane0_rden1,
  output logic dec_lane0_rden2,
  output logic dec_lane1_valid,
  output issue_pkg::op_class_e dec_lane1_op_class,
  output issue_pkg::alu_op_e dec_lane1_alu_op,
  output logic [issue_pkg::reg_addr_width-1:0] dec_lane1_waddr,
  output logic [issue_pkg::reg_addr_width-1:0] dec_lane1_raddr1,
  output logic [issue_pkg::reg_addr_width-1:0] dec_lane1_raddr2,
  output logic [issue_pkg::xlen-1:0] dec_lane1_imm,
  output logic dec_lane1_wren,
  output logic dec_lane1_rden1,
  output logic dec_lane1_rden2
);

  logic [issue_pkg::xlen-1:0] word [2];
  logic [1:0] word_valid;

  logic [1:0] uses_rd, uses_rs1, uses_rs2;
  logic [1:0] n_valid, n_wren, n_rden1, n_rden2;
  issue_pkg::op_class_e n_class [2];
  issue_pkg::alu_op_e n_alu [2];
  logic [issue_pkg::xlen-1:0] n_imm [2];

  logic [1:0] r_valid, r_wren, r_rden1, r_rden2;
  issue_pkg::op_class_e r_class [2];
  issue_pkg::alu_op_e r_alu [2];
  logic [issue_pkg::reg_addr_width-1:0] r_waddr [2], r_raddr1 [2], r_raddr2 [2];
  logic [issue_pkg::xlen-1:0] r_imm [2];

  assign word[0] = word0;
  assign word[1] = word1;
  assign word_valid = {word1_valid, word0_valid};

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      n_class[i] = issue_pkg::class_none;
      n_alu[i] = issue_pkg::alu_nop;
      n_imm[i] = {{20{word[i][31]}}, word[i][31:20]}; // i-type unless overridden
      uses_rd[i] = 1'b0;
      uses_rs1[i] = 1'b0;
      uses_rs2[i] = 1'b0;
      case (word[i][6:0])
        issue_pkg::opc_op: begin
          if (word[i][14:12] == 3'b000) begin
            uses_rd[i] = 1'b1;
            uses_rs1[i] = 1'b1;
            uses_rs2[i] = 1'b1;
            case (word[i][31:25])
              7'h00: begin
                n_class[i] = issue_pkg::class_alu;
                n_alu[i] = issue_pkg::alu_add;
              end
              7'h20: begin
                n_class[i] = issue_pkg::class_alu;
                n_alu[i] = issue_pkg::alu_sub;
              end
              7'h01: begin
                n_class[i] = issue_pkg::class_mul;
                n_alu[i] = issue_pkg::alu_mul;
              end
              default: n_class[i] = issue_pkg::class_none;
            endcase
          end
        end
        issue_pkg::opc_op_imm: begin
          if (word[i][14:12] == 3'b000) begin
            n_class[i] = issue_pkg::class_alu;
            n_alu[i] = issue_pkg::alu_addi;
            uses_rd[i] = 1'b1;
            uses_rs1[i] = 1'b1;
          end
        end
        issue_pkg::opc_lui: begin
          n_class[i] = issue_pkg::class_alu;
          n_alu[i] = issue_pkg::alu_lui;
          n_imm[i] = {word[i][31:12], 12'b0};
          uses_rd[i] = 1'b1;
        end
        issue_pkg::opc_load: begin
          n_class[i] = issue_pkg::class_load; // address base only, no write back here
          uses_rs1[i] = 1'b1;
        end
        issue_pkg::opc_store: begin
          n_class[i] = issue_pkg::class_store;
          n_imm[i] = {{20{word[i][31]}}, word[i][31:25], word[i][11:7]};
          uses_rs1[i] = 1'b1;
          uses_rs2[i] = 1'b1;
        end
        issue_pkg::opc_system: begin
          if (word[i][14:12] != 3'b000) begin
            n_class[i] = issue_pkg::class_csr;
            uses_rs1[i] = !word[i][14]; // immediate forms carry a zimm in rs1
          end
        end
        issue_pkg::opc_fence: n_class[i] = issue_pkg::class_fence;
        default: n_class[i] = issue_pkg::class_none;
      endcase
      n_valid[i] = word_valid[i] && (n_class[i] != issue_pkg::class_none);
      n_wren[i] = uses_rd[i] && (word[i][11:7] != '0);
      n_rden1[i] = uses_rs1[i] && (word[i][19:15] != '0);
      n_rden2[i] = uses_rs2[i] && (word[i][24:20] != '0);
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r_valid <= '0;
    end else if (!stall) begin
      r_valid <= n_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin // records stay put until the queue takes them
      for (int i = 0; i < 2; i++) begin
        r_class[i] <= n_class[i];
        r_alu[i] <= n_alu[i];
        r_waddr[i] <= word[i][11:7];
        r_raddr1[i] <= word[i][19:15];
        r_raddr2[i] <= word[i][24:20];
        r_imm[i] <= n_imm[i];
        r_wren[i] <= n_wren[i];
        r_rden1[i] <= n_rden1[i];
        r_rden2[i] <= n_rden2[i];
      end
    end
  end

  assign {dec_lane0_valid, dec_lane0_op_class, dec_lane0_alu_op} = {r_valid[0], r_class[0], r_alu[0]};
  assign {dec_lane1_valid, dec_lane1_op_class, dec_lane1_alu_op} = {r_valid[1], r_class[1], r_alu[1]};
  assign {dec_lane0_waddr, dec_lane0_raddr1, dec_lane0_raddr2} = {r_waddr[0], r_raddr1[0], r_raddr2[0]};
  assign {dec_lane1_waddr, dec_lane1_raddr1, dec_lane1_raddr2} = {r_waddr[1], r_raddr1[1], r_raddr2[1]};
  assign {dec_lane0_wren, dec_lane0_rden1, dec_lane0_rden2} = {r_wren[0], r_rden1[0], r_rden2[0]};
  assign {dec_lane1_wren, dec_lane1_rden1, dec_lane1_rden2} = {r_wren[1], r_rden1[1], r_rden2[1]};
  assign dec_lane0_imm = r_imm[0];
  assign dec_lane1_imm = r_imm[1];

endmodule

/* source/hazard_queue.sv */
module hazard_queue #(
  parameter int queue_depth = 8
) (
  input  logic clock,
  input  logic reset,
  input  logic hold,
  input  logic flush,
  input  logic dec_lane0_valid,
  input  issue_pkg::op_class_e dec_lane0_op_class,
  input  issue_pkg::alu_op_e dec_lane0_alu_op,
  input  logic [issue_pkg::reg_addr_width-1:0] dec_lane0_waddr,
  input  logic [issue_pkg::reg_addr_width-1:0] dec_lane0_raddr1,
  input  logic [issue_pkg::reg_addr_width-1:0] dec_lane0_raddr2,
  input  logic [issue_pkg::xlen-1:0] dec_lane0_imm,
  input  logic dec_lane0_wren,
  input  logic dec_lane0_rden1,
  input  logic dec_lane0_rden2,
  input  logic dec_lane1_valid,
  input  issue_pkg::op_class_e dec_lane1_op_class,
  input  issue_pkg::alu_op_e dec_lane1_alu_op,
  input  logic [issue_pkg::reg_addr_width-1:0] dec_lane1_waddr,
  input  logic [issue_pkg::reg_addr_width-1:0] dec_lane1_raddr1,
  input  logic [issue_pkg::reg_addr_width-1:0] dec_lane1_raddr2,
  input  logic [issue_pkg::xlen-1:0] dec_lane1_imm,
  input  logic dec_lane1_wren,
  input  logic dec_lane1_rden1,
  input  logic dec_lane1_rden2,
  output logic iss_lane0_valid,
  output issue_pkg::op_class_e iss_lane0_op_class,
  output issue_pkg::alu_op_e iss_lane0_alu_op,
  output logic [issue_pkg::reg_addr_width-1:0] iss_lane0_waddr,
  output logic [issue_pkg::reg_addr_width-1:0] iss_lane0_raddr1,
  output logic [issue_pkg::reg_addr_width-1:0] iss_lane0_raddr2,
  output logic [issue_pkg::xlen-1:0] iss_lane0_imm,
  output logic iss_lane0_wren,
  output logic iss_lane0_rden1,
  output logic iss_lane0_rden2,
  output logic iss_lane1_valid,
  output issue_pkg::op_class_e iss_lane1_op_class,
  output issue_pkg::alu_op_e iss_lane1_alu_op,
  output logic [issue_pkg::reg_addr_width-1:0] iss_lane1_waddr,
  output logic [issue_pkg::reg_addr_width-1:0] iss_lane1_raddr1,
  output logic [issue_pkg::reg_addr_width-1:0] iss_lane1_raddr2,
  output logic [issue_pkg::xlen-1:0] iss_lane1_imm,
  output logic iss_lane1_wren,
  output logic iss_lane1_rden1,
  output logic iss_lane1_rden2,
  output logic stall
);

  localparam int ptr_width = $clog2(queue_depth);

  typedef struct packed {
    issue_pkg::op_class_e op_class;
    issue_pkg::alu_op_e alu_op;
    logic [issue_pkg::reg_addr_width-1:0] waddr;
    logic [issue_pkg::reg_addr_width-1:0] raddr1;
    logic [issue_pkg::reg_addr_width-1:0] raddr2;
    logic [issue_pkg::xlen-1:0] imm;
    logic wren;
    logic rden1;
    logic rden2;
  } entry_t;

  entry_t mem [queue_depth];
  entry_t in0, in1, first_in, slot0, slot1;

  logic [ptr_width-1:0] wr_ptr, wr_ptr1, rd_ptr, rd_ptr1;
  logic [ptr_width:0] count, avail, count_next;
  logic [1:0] n_in, pass;
  logic write_en, single, same_unit, raw;

  assign in0 = {dec_lane0_op_class, dec_lane0_alu_op, dec_lane0_waddr, dec_lane0_raddr1,
                dec_lane0_raddr2, dec_lane0_imm, dec_lane0_wren, dec_lane0_rden1, dec_lane0_rden2};
  assign in1 = {dec_lane1_op_class, dec_lane1_alu_op, dec_lane1_waddr, dec_lane1_raddr1,
                dec_lane1_raddr2, dec_lane1_imm, dec_lane1_wren, dec_lane1_rden1, dec_lane1_rden2};

  // ~~~~~~~~~~~~~~~~~~~~
  // view of the queue after this cycle's writes

  assign write_en = !stall && !flush;
  assign n_in = write_en ? {1'b0, dec_lane0_valid} + {1'b0, dec_lane1_valid} : 2'd0;
  assign avail = count + (ptr_width + 1)'(n_in);
  assign first_in = dec_lane0_valid ? in0 : in1;
  assign wr_ptr1 = wr_ptr + 1'b1;
  assign rd_ptr1 = rd_ptr + 1'b1;

  assign slot0 = (count != 0) ? mem[rd_ptr] : first_in; // empty queue issues on arrival
  assign slot1 = (count > 1) ? mem[rd_ptr1] : ((count == 1) ? first_in : in1);

  // ~~~~~~~~~~~~~~~~~~~~
  // pairing rules

  assign single = (slot0.op_class == issue_pkg::class_fence) ||
                  (slot1.op_class == issue_pkg::class_fence);
  assign same_unit =
    ((slot0.op_class inside {issue_pkg::class_load, issue_pkg::class_store}) &&
     (slot1.op_class inside {issue_pkg::class_load, issue_pkg::class_store})) ||
    ((slot0.op_class == issue_pkg::class_mul) && (slot1.op_class == issue_pkg::class_mul)) ||
    ((slot0.op_class == issue_pkg::class_csr) && (slot1.op_class == issue_pkg::class_csr));
  assign raw = slot0.wren && ((slot1.rden1 && (slot1.raddr1 == slot0.waddr)) ||
                              (slot1.rden2 && (slot1.raddr2 == slot0.waddr)));

  always_comb begin
    if (hold || flush) begin
      pass = 2'd0;
    end else if (single || same_unit || raw) begin
      pass = 2'd1;
    end else begin
      pass = 2'd2;
    end
    if (avail < (ptr_width + 1)'(pass)) begin
      pass = avail[1:0]; // never issue more than is held
    end
  end

  assign count_next = avail - (ptr_width + 1)'(pass);

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      stall <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr + ptr_width'(n_in);
      rd_ptr <= rd_ptr + ptr_width'(pass);
      count <= count_next;
      stall <= (count_next > (queue_depth / 2)); // leaves room for one more pair
    end
  end

  always_ff @(posedge clock) begin
    if (write_en && dec_lane0_valid) begin
      mem[wr_ptr] <= in0;
    end
    if (write_en && dec_lane1_valid) begin
      mem[dec_lane0_valid ? wr_ptr1 : wr_ptr] <= in1;
    end
  end

  assign iss_lane0_valid = (pass != 2'd0);
  assign iss_lane1_valid = (pass == 2'd2);
  assign {iss_lane0_op_class, iss_lane0_alu_op, iss_lane0_waddr, iss_lane0_raddr1,
          iss_lane0_raddr2, iss_lane0_imm, iss_lane0_wren, iss_lane0_rden1,
          iss_lane0_rden2} = slot0;
  assign {iss_lane1_op_class, iss_lane1_alu_op, iss_lane1_waddr, iss_lane1_raddr1,
          iss_lane1_raddr2, iss_lane1_imm, iss_lane1_wren, iss_lane1_rden1,
          iss_lane1_rden2} = slot1;

endmodule

/* source/dual_exec.sv */
module dual_exec (
  input  logic clock,
  input  logic reset,
  input  logic iss_lane0_valid,
  input  issue_pkg::op_class_e iss_lane0_op_class,
  input  issue_pkg::alu_op_e iss_lane0_alu_op,
  input  logic [issue_pkg::reg_addr_width-1:0] iss_lane0_waddr,
  input  logic [issue_pkg::reg_addr_width-1:0] iss_lane0_raddr1,
  input  logic [issue_pkg::reg_addr_width-1:0] iss_lane0_raddr2,
  input  logic [issue_pkg::xlen-1:0] iss_lane0_imm,
  input  logic iss_lane0_wren,
  input  logic iss_lane0_rden1,
  input  logic iss_lane0_rden2,
  input  logic iss_lane1_valid,
  input  issue_pkg::op_class_e iss_lane1_op_class,
  input  issue_pkg::alu_op_e iss_lane1_alu_op,
  input  logic [issue_pkg::reg_addr_width-1:0] iss_lane1_waddr,
  input  logic [issue_pkg::reg_addr_width-1:0] iss_lane1_raddr1,
  input  logic [issue_pkg::reg_addr_width-1:0] iss_lane1_raddr2,
  input  logic [issue_pkg::xlen-1:0] iss_lane1_imm,
  input  logic iss_lane1_wren,
  input  logic iss_lane1_rden1,
  input  logic iss_lane1_rden2,
  input  logic [issue_pkg::reg_addr_width-1:0] probe_addr,
  output logic [issue_pkg::xlen-1:0] probe_data,
  output logic [15:0] retired_count
);

  localparam int reg_count = 2 ** issue_pkg::reg_addr_width;

  logic [issue_pkg::xlen-1:0] regs [reg_count];
  logic [issue_pkg::xlen-1:0] a0, b0, a1, b1, res0, res1;
  logic we0, we1;

  function automatic logic [issue_pkg::xlen-1:0] compute(
    input issue_pkg::alu_op_e op,
    input logic [issue_pkg::xlen-1:0] a,
    input logic [issue_pkg::xlen-1:0] b,
    input logic [issue_pkg::xlen-1:0] imm
  );
    case (op)
      issue_pkg::alu_add: return a + b;
      issue_pkg::alu_sub: return a - b;
      issue_pkg::alu_addi: return a + imm;
      issue_pkg::alu_lui: return imm;
      issue_pkg::alu_mul: return a * b; // low half only
      default: return '0;
    endcase
  endfunction

  // both lanes read the old register state
  assign a0 = iss_lane0_rden1 ? regs[iss_lane0_raddr1] : '0;
  assign b0 = iss_lane0_rden2 ? regs[iss_lane0_raddr2] : '0;
  assign a1 = iss_lane1_rden1 ? regs[iss_lane1_raddr1] : '0;
  assign b1 = iss_lane1_rden2 ? regs[iss_lane1_raddr2] : '0;

  assign res0 = compute(iss_lane0_alu_op, a0, b0, iss_lane0_imm);
  assign res1 = compute(iss_lane1_alu_op, a1, b1, iss_lane1_imm);

  assign we0 = iss_lane0_valid && iss_lane0_wren && (iss_lane0_waddr != '0) &&
               (iss_lane0_op_class inside {issue_pkg::class_alu, issue_pkg::class_mul});
  assign we1 = iss_lane1_valid && iss_lane1_wren && (iss_lane1_waddr != '0) &&
               (iss_lane1_op_class inside {issue_pkg::class_alu, issue_pkg::class_mul});

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
      retired_count <= '0;
    end else begin
      if (we0) begin
        regs[iss_lane0_waddr] <= res0;
      end
      if (we1) begin
        regs[iss_lane1_waddr] <= res1; // younger lane wins a shared target
      end
      retired_count <= retired_count + 16'(iss_lane0_valid) + 16'(iss_lane1_valid);
    end
  end

  assign probe_data = (probe_addr == '0) ? '0 : regs[probe_addr];

endmodule

/* source/issue_top.sv */
module issue_top #(
  parameter int queue_depth = 8
) (
  input  logic clock,
  input  logic reset,
  input  logic word0_valid,
  input  logic [issue_pkg::xlen-1:0] word0,
  input  logic word1_valid,
  input  logic [issue_pkg::xlen-1:0] word1,
  input  logic hold,
  input  logic flush,
  input  logic [issue_pkg::reg_addr_width-1:0] probe_addr,
  output logic fetch_stall,
  output logic [issue_pkg::xlen-1:0] probe_data,
  output logic [15:0] retired_count
);

  // ~~~~~~~~~~~~~~~~~~~~
  // decoded and issued lane records

  logic dec_lane0_valid, dec_lane0_wren, dec_lane0_rden1, dec_lane0_rden2;
  logic dec_lane1_valid, dec_lane1_wren, dec_lane1_rden1, dec_lane1_rden2;
  logic iss_lane0_valid, iss_lane0_wren, iss_lane0_rden1, iss_lane0_rden2;
  logic iss_lane1_valid, iss_lane1_wren, iss_lane1_rden1, iss_lane1_rden2;
  issue_pkg::op_class_e dec_lane0_op_class, dec_lane1_op_class;
  issue_pkg::op_class_e iss_lane0_op_class, iss_lane1_op_class;
  issue_pkg::alu_op_e dec_lane0_alu_op, dec_lane1_alu_op, iss_lane0_alu_op, iss_lane1_alu_op;
  logic [issue_pkg::reg_addr_width-1:0] dec_lane0_waddr, dec_lane0_raddr1, dec_lane0_raddr2;
  logic [issue_pkg::reg_addr_width-1:0] dec_lane1_waddr, dec_lane1_raddr1, dec_lane1_raddr2;
  logic [issue_pkg::reg_addr_width-1:0] iss_lane0_waddr, iss_lane0_raddr1, iss_lane0_raddr2;
  logic [issue_pkg::reg_addr_width-1:0] iss_lane1_waddr, iss_lane1_raddr1, iss_lane1_raddr2;
  logic [issue_pkg::xlen-1:0] dec_lane0_imm, dec_lane1_imm, iss_lane0_imm, iss_lane1_imm;

  pair_decoder decoder_i (.stall(fetch_stall), .*);

  hazard_queue #(.queue_depth(queue_depth)) queue_i (.stall(fetch_stall), .*);

  dual_exec exec_i (.*);

endmodule

/* bench/issue_tb.sv */
module issue_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_cycles = 200;

  localparam logic [2:0] k_add = 3'd0;
  localparam logic [2:0] k_sub = 3'd1;
  localparam logic [2:0] k_addi = 3'd2;
  localparam logic [2:0] k_lui = 3'd3;
  localparam logic [2:0] k_mul = 3'd4;

  localparam logic [31:0] store_word = {7'd0, 5'd1, 5'd2, 3'b010, 5'd0, 7'b0100011}; // sw x1, 0(x2)
  localparam logic [31:0] fence_word = {4'd0, 4'hf, 4'hf, 5'd0, 3'b000, 5'd0, 7'b0001111};

  typedef struct packed {
    logic [2:0] kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [19:0] imm;
  } instr_t;

  logic clock, reset, word0_valid, word1_valid, hold, flush, fetch_stall;
  logic [31:0] word0, word1, probe_data;
  logic [4:0] probe_addr;
  logic [15:0] retired_count;

  logic [31:0] ref_regs [32];
  logic [15:0] expected_retired;
  logic [31:0] rng_state;
  int rate_on;
  int rate_q;
  logic hold_q;
  logic [15:0] retired_q;
  instr_t a, b;

  issue_top #(.queue_depth(8)) dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    hold_q <= hold;
    rate_q <= rate_on;
    retired_q <= retired_count; // count as it stood before this edge
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // failure reporting and helpers

  task automatic fail_value(input string test, input logic [31:0] expected,
                            input logic [31:0] actual);
    $display("ERR %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
    $display("STATUS: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic fail_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("STATUS: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  // a held cycle retires nothing
  hold_check: assert property (@(negedge clock) disable iff (!reset)
    hold_q |-> retired_count == retired_q)
    else fail_value("hold", 32'(retired_q), 32'(retired_count));

  rate_check: assert property (@(negedge clock) disable iff (!reset)
    (rate_q != 0) |-> (retired_count - retired_q) == 16'(rate_q))
    else fail_value("issue rate", 32'(rate_q), 32'(retired_count - retired_q));

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] encode(input instr_t i);
    case (i.kind)
      k_add: return {7'h00, i.rs2, i.rs1, 3'b000, i.rd, 7'b0110011};
      k_sub: return {7'h20, i.rs2, i.rs1, 3'b000, i.rd, 7'b0110011};
      k_mul: return {7'h01, i.rs2, i.rs1, 3'b000, i.rd, 7'b0110011};
      k_addi: return {i.imm[11:0], i.rs1, 3'b000, i.rd, 7'b0010011};
      default: return {i.imm, i.rd, 7'b0110111}; // lui
    endcase
  endfunction

  function automatic instr_t rand_instr(input logic [31:0] lo, input logic [31:0] span);
    instr_t i;
    i.kind = 3'(next_rand() % 5);
    i.rd = 5'(lo + next_rand() % span);
    i.rs1 = 5'(lo + next_rand() % span);
    i.rs2 = 5'(lo + next_rand() % span);
    i.imm = 20'(next_rand());
    return i;
  endfunction

  // sequential rv32 semantics in program order
  task automatic model_instr(input instr_t i);
    logic [31:0] x, y, r;
    x = ref_regs[i.rs1];
    y = ref_regs[i.rs2];
    case (i.kind)
      k_add: r = x + y;
      k_sub: r = x - y;
      k_mul: r = x * y;
      k_addi: r = x + {{20{i.imm[11]}}, i.imm[11:0]};
      default: r = {i.imm, 12'b0};
    endcase
    if (i.rd != 5'd0) begin
      ref_regs[i.rd] = r;
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #2;
  endtask

  // keeps the pair on the inputs until an edge where stall was low
  task automatic send_pair(input logic [31:0] w0, input logic [31:0] w1);
    int waited;
    logic taken;
    waited = 0;
    taken = 1'b0;
    word0 = w0;
    word1 = w1;
    word0_valid = 1'b1;
    word1_valid = 1'b1;
    while (!taken) begin
      taken = !fetch_stall; // this level decides the coming edge
      next_cycle();
      waited++;
      if (waited > timeout_cycles) fail_timeout("a word pair to be accepted");
    end
    word0_valid = 1'b0;
    word1_valid = 1'b0;
  endtask

  task automatic send_instr_pair(input instr_t i0, input instr_t i1);
    send_pair(encode(i0), encode(i1));
    model_instr(i0);
    model_instr(i1);
    expected_retired += 16'd2;
  endtask

  task automatic wait_stall(input logic level);
    int waited;
    waited = 0;
    while (fetch_stall !== level) begin
      next_cycle();
      waited++;
      if (waited > timeout_cycles) fail_timeout("fetch_stall to change");
    end
  endtask

  task automatic wait_retired(input string test);
    int waited;
    waited = 0;
    while (retired_count < expected_retired) begin
      next_cycle();
      waited++;
      if (waited > timeout_cycles) fail_timeout("the retirement target");
    end
    assert (retired_count == expected_retired)
      else fail_value(test, 32'(expected_retired), 32'(retired_count));
  endtask

  task automatic check_regs(input string test);
    for (int r = 0; r < 32; r++) begin
      probe_addr = 5'(r);
      #1;
      assert (probe_data == ref_regs[r]) else fail_value(test, ref_regs[r], probe_data);
      next_cycle();
    end
  endtask

  task automatic drain_at_rate(input int rate, input int total, input string test);
    hold = 1'b0;
    rate_on = rate;
    repeat (total / rate) next_cycle();
    rate_on = 0;
    wait_retired(test);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // program

  initial begin
    reset = 1'b0;
    word0_valid = 1'b0;
    word1_valid = 1'b0;
    word0 = '0;
    word1 = '0;
    hold = 1'b0;
    flush = 1'b0;
    probe_addr = '0;
    rng_state = 32'd50;
    expected_retired = '0;
    rate_on = 0;
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = '0;
    end
    repeat (10) @(posedge clock);
    #2;
    reset = 1'b1;

    assert (retired_count == 16'd0) else fail_value("reset retired_count", 0, 32'(retired_count));
    assert (fetch_stall == 1'b0) else fail_value("reset fetch_stall", 0, 32'(fetch_stall));
    check_regs("reset registers");

    for (int n = 0; n < 40; n++) begin
      a = rand_instr(1, 15); // lane 0 in x1..x15, lane 1 in x16..x31
      b = rand_instr(16, 16);
      send_instr_pair(a, b);
    end
    wait_retired("arithmetic retired_count");
    check_regs("arithmetic registers");

    for (int n = 0; n < 24; n++) begin
      a = rand_instr(1, 31);
      b = rand_instr(1, 31);
      b.rs1 = a.rd;
      if (b.kind == k_lui) b.kind = k_addi;
      if (next_rand() % 2 == 0) b.rs2 = a.rd;
      send_instr_pair(a, b);
    end
    wait_retired("raw retired_count");
    check_regs("raw registers");

    hold = 1'b1;
    repeat (4) begin
      send_pair(store_word, store_word);
      expected_retired += 16'd2;
    end
    wait_stall(1'b1);
    drain_at_rate(1, 8, "store retired_count");

    hold = 1'b1;
    repeat (4) begin
      send_pair(fence_word, fence_word);
      expected_retired += 16'd2;
    end
    wait_stall(1'b1);
    drain_at_rate(1, 8, "fence retired_count");

    hold = 1'b1;
    for (int n = 0; n < 4; n++) begin
      a = '{kind: k_addi, rd: 5'(20 + 2 * n), rs1: 5'd0, rs2: 5'd0, imm: 20'(100 + n)};
      b = '{kind: k_addi, rd: 5'(21 + 2 * n), rs1: 5'd0, rs2: 5'd0, imm: 20'(200 + n)};
      send_instr_pair(a, b);
    end
    wait_stall(1'b1);
    drain_at_rate(2, 8, "addi retired_count");
    check_regs("addi registers");

    hold = 1'b1;
    repeat (4) send_instr_pair(rand_instr(1, 31), rand_instr(1, 31));
    wait_stall(1'b1);
    a = rand_instr(1, 31);
    b = rand_instr(1, 31);
    word0 = encode(a);
    word1 = encode(b);
    word0_valid = 1'b1;
    word1_valid = 1'b1;
    repeat (6) next_cycle(); // ignored while stalled, so sent again below
    hold = 1'b0;
    send_instr_pair(a, b);
    repeat (6) send_instr_pair(rand_instr(1, 31), rand_instr(1, 31));
    wait_retired("back-pressure retired_count");
    check_regs("back-pressure registers");

    hold = 1'b1;
    repeat (3) send_pair(encode(rand_instr(1, 31)), encode(rand_instr(1, 31)));
    wait_stall(1'b1);
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    assert (fetch_stall == 1'b0) else fail_value("flush fetch_stall", 0, 32'(fetch_stall));
    hold = 1'b0;
    repeat (12) next_cycle(); // flushed work must never show up
    assert (retired_count == expected_retired)
      else fail_value("flush retired_count", 32'(expected_retired), 32'(retired_count));
    check_regs("flush registers");

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* files.f */
source/issue_pkg.sv
source/pair_decoder.sv
source/hazard_queue.sv
source/dual_exec.sv
source/issue_top.sv
bench/issue_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module issue_tb -f files.f -o issue_sim

./obj_dir/issue_sim 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
